// File: source/stream_pkg.sv
////////////////////////////////////////
// stream geometry for the packet checker
// shared by decode, compare and top level
////////////////////////////////////////

package stream_pkg;

    // bytes carried per beat
    localparam int DATA_BYTES = 4;
    localparam int DATA_W = DATA_BYTES * 8;

    // largest packet accepted
    localparam int MTU_BYTES = 64;
    localparam int MTU_WORDS = MTU_BYTES / DATA_BYTES;

    // word index within a packet
    localparam int WORD_IDX_W = $clog2(MTU_WORDS);

    // byte length, one extra bit so MTU_BYTES fits
    localparam int BLEN_W = $clog2(MTU_BYTES) + 1;

endpackage

// File: source/check_pkg.sv
////////////////////////////////////////
// expected-packet table sizes and the
// verdict encoding given per packet
////////////////////////////////////////

package check_pkg;

    // expected-packet slots
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_W = $clog2(NUM_SLOTS);

    // match and miss counter width
    localparam int CNT_W = 16;

    // outcome for one finished packet
    typedef enum logic [1:0] {
        vd_match,
        vd_repeat,
        vd_miss,
        vd_malformed
    } verdict_e;

endpackage

// File: source/beat_if.sv
////////////////////////////////////////
// one decoded beat, decode to compare
////////////////////////////////////////

`timescale 1ns/100ps

interface beat_if import stream_pkg::*; ();

    // one-cycle strobe per accepted beat
    logic                  valid;
    logic                  last;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [DATA_W-1:0]     data;
    // tkeep as it came in
    logic [DATA_BYTES-1:0] byte_mask;
    // bytes so far, this beat included
    logic [BLEN_W-1:0]     blen;
    // sticky format error of the packet
    logic                  bad;

    modport src (
        output valid, last, word_idx, data, byte_mask, blen, bad
    );

    modport dst (
        input valid, last, word_idx, data, byte_mask, blen, bad
    );

endinterface

// File: source/beat_decode.sv
////////////////////////////////////////
// stream input stage, registers beats and
// tracks index, byte count and format
////////////////////////////////////////

`timescale 1ns/100ps

module beat_decode import stream_pkg::*; (
    input  logic                  axis_in,
    input  logic                  rst,
    input  logic [DATA_W-1:0]     tdata,
    input  logic [DATA_BYTES-1:0] tkeep,
    input  logic                  tvalid,
    input  logic                  tlast,
    output logic                  tready,
    beat_if.src                   beat
);

    // one extra bit to see the MTU overrun
    logic [WORD_IDX_W:0] word_cnt;
    logic [BLEN_W-1:0]   blen_acc;
    logic                bad_acc;
    logic                accept;
    logic [BLEN_W-1:0]   blen_now;
    logic                bad_now;

    // contiguous from byte 0 and not empty
    function automatic logic keep_ok(input logic [DATA_BYTES-1:0] k);
        logic [DATA_BYTES-1:0] inc;
        inc = k + 1'b1;
        return (k != '0) && ((k & inc) == '0);
    endfunction

    function automatic logic [BLEN_W-1:0] ones(input logic [DATA_BYTES-1:0] k);
        logic [BLEN_W-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n = n + k[i];
        end
        return n;
    endfunction

    // never back-pressures
    assign accept = tvalid && tready;
    assign blen_now = blen_acc + ones(tkeep);
    // partial keep only allowed on last beat
    assign bad_now = bad_acc || !keep_ok(tkeep) || (!tlast && tkeep != '1)
                     || (word_cnt >= MTU_WORDS);

    always_ff @(posedge axis_in) begin
        if (rst) begin
            tready     <= 1'b0;
            beat.valid <= 1'b0;
            word_cnt   <= '0;
            blen_acc   <= '0;
            bad_acc    <= 1'b0;
        end else begin
            tready     <= 1'b1;
            beat.valid <= accept;
            if (accept) begin
                if (tlast) begin
                    // next beat opens a new packet
                    word_cnt <= '0;
                    blen_acc <= '0;
                    bad_acc  <= 1'b0;
                end else begin
                    // saturate once past the MTU
                    if (word_cnt != MTU_WORDS) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    blen_acc <= blen_now;
                    bad_acc  <= bad_now;
                end
            end
        end
    end

    // beat payload
    always_ff @(posedge axis_in) begin
        if (accept) begin
            beat.last      <= tlast;
            beat.word_idx  <= word_cnt[WORD_IDX_W-1:0];
            beat.data      <= tdata;
            beat.byte_mask <= tkeep;
            beat.blen      <= blen_now;
            beat.bad       <= bad_now;
        end
    end

endmodule

// File: source/expect_table.sv
////////////////////////////////////////
// expected words and lengths per slot,
// one word index read from all slots
////////////////////////////////////////

`timescale 1ns/100ps

module expect_table import stream_pkg::*, check_pkg::*; (
    input  logic                                axis_in,
    input  logic                                rst,
    input  logic                                tbl_we,
    input  logic [SLOT_W-1:0]                   tbl_slot,
    input  logic [WORD_IDX_W-1:0]               tbl_word,
    input  logic [DATA_W-1:0]                   tbl_wdata,
    input  logic                                len_we,
    input  logic [BLEN_W-1:0]                   len_bytes,
    input  logic [WORD_IDX_W-1:0]               rd_word_idx,
    output logic [NUM_SLOTS-1:0][DATA_W-1:0]    rd_words,
    output logic [NUM_SLOTS-1:0][BLEN_W-1:0]    slot_blen
);

    logic [DATA_W-1:0] words [NUM_SLOTS][MTU_WORDS];

    // word store
    always_ff @(posedge axis_in) begin
        if (tbl_we) begin
            words[tbl_slot][tbl_word] <= tbl_wdata;
        end
    end

    // zero length marks an empty slot
    always_ff @(posedge axis_in) begin
        if (rst) begin
            slot_blen <= '0;
        end else if (len_we) begin
            slot_blen[tbl_slot] <= len_bytes;
        end
    end

    // same index across every slot
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            rd_words[s] = words[s][rd_word_idx];
        end
    end

endmodule

// File: source/slot_compare.sv
////////////////////////////////////////
// compares beats against all slots,
// gives the final candidate mask per packet
////////////////////////////////////////

`timescale 1ns/100ps

module slot_compare import stream_pkg::*, check_pkg::*; (
    input  logic                  axis_in,
    input  logic                  rst,
    beat_if.dst                   beat,
    input  logic                  tbl_we,
    input  logic [SLOT_W-1:0]     tbl_slot,
    input  logic [WORD_IDX_W-1:0] tbl_word,
    input  logic [DATA_W-1:0]     tbl_wdata,
    input  logic                  len_we,
    input  logic [BLEN_W-1:0]     len_bytes,
    output logic                  done,
    output logic [NUM_SLOTS-1:0]  cand_mask,
    output logic                  bad
);

    logic [NUM_SLOTS-1:0][DATA_W-1:0] rd_words;
    logic [NUM_SLOTS-1:0][BLEN_W-1:0] slot_blen;
    logic [NUM_SLOTS-1:0]             cand_q;
    logic [NUM_SLOTS-1:0]             cand_nxt;

    expect_table u_table (
        .axis_in     (axis_in),
        .rst         (rst),
        .tbl_we      (tbl_we),
        .tbl_slot    (tbl_slot),
        .tbl_word    (tbl_word),
        .tbl_wdata   (tbl_wdata),
        .len_we      (len_we),
        .len_bytes   (len_bytes),
        .rd_word_idx (beat.word_idx),
        .rd_words    (rd_words),
        .slot_blen   (slot_blen)
    );

    always_comb begin
        // word 0 reopens every slot
        cand_nxt = (beat.word_idx == '0) ? '1 : cand_q;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            // only bytes kept by tkeep count
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (beat.byte_mask[b] && beat.data[b*8 +: 8] != rd_words[s][b*8 +: 8]) begin
                    cand_nxt[s] = 1'b0;
                end
            end
            // length check at packet end, empty slots drop out
            if (beat.last && (slot_blen[s] != beat.blen || slot_blen[s] == '0)) begin
                cand_nxt[s] = 1'b0;
            end
        end
    end

    always_ff @(posedge axis_in) begin
        if (rst) begin
            cand_q <= '0;
            done   <= 1'b0;
        end else begin
            done <= beat.valid && beat.last;
            if (beat.valid) begin
                cand_q <= cand_nxt;
            end
        end
    end

    // packet result
    always_ff @(posedge axis_in) begin
        if (beat.valid && beat.last) begin
            cand_mask <= cand_nxt;
            bad       <= beat.bad;
        end
    end

endmodule

// File: source/verdict_select.sv
////////////////////////////////////////
// picks the verdict, claims matched slots
// and counts matches and misses
////////////////////////////////////////

`timescale 1ns/100ps

module verdict_select import check_pkg::*; (
    input  logic                 axis_in,
    input  logic                 rst,
    input  logic                 done,
    input  logic [NUM_SLOTS-1:0] cand_mask,
    input  logic                 bad,
    input  logic                 len_we,
    input  logic [SLOT_W-1:0]    len_slot,
    output logic                 verdict_valid,
    output verdict_e             verdict,
    output logic [SLOT_W-1:0]    verdict_slot,
    output logic [CNT_W-1:0]     match_count,
    output logic [CNT_W-1:0]     miss_count
);

    logic [NUM_SLOTS-1:0] claimed;
    logic [NUM_SLOTS-1:0] free_hit;
    logic [NUM_SLOTS-1:0] used_hit;
    logic [SLOT_W-1:0]    free_slot;
    logic [SLOT_W-1:0]    used_slot;

    // lowest set bit wins
    function automatic logic [SLOT_W-1:0] lowest(input logic [NUM_SLOTS-1:0] m);
        logic [SLOT_W-1:0] idx;
        idx = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = SLOT_W'(i);
            end
        end
        return idx;
    endfunction

    assign free_hit  = cand_mask & ~claimed;
    assign used_hit  = cand_mask & claimed;
    assign free_slot = lowest(free_hit);
    assign used_slot = lowest(used_hit);

    always_ff @(posedge axis_in) begin
        if (rst) begin
            claimed       <= '0;
            verdict_valid <= 1'b0;
            match_count   <= '0;
            miss_count    <= '0;
        end else begin
            verdict_valid <= done;
            if (done && !bad && free_hit != '0) begin
                claimed[free_slot] <= 1'b1;
                match_count        <= match_count + 1'b1;
            end else if (done) begin
                // repeat, miss and malformed
                miss_count <= miss_count + 1'b1;
            end
            // new length frees the slot again
            if (len_we) begin
                claimed[len_slot] <= 1'b0;
            end
        end
    end

    // malformed first, then match, repeat, miss
    always_ff @(posedge axis_in) begin
        if (done) begin
            verdict_slot <= '0;
            if (bad) begin
                verdict <= vd_malformed;
            end else if (free_hit != '0) begin
                verdict      <= vd_match;
                verdict_slot <= free_slot;
            end else if (used_hit != '0) begin
                verdict      <= vd_repeat;
                verdict_slot <= used_slot;
            end else begin
                verdict <= vd_miss;
            end
        end
    end

endmodule

// File: source/pkt_checker_top.sv
////////////////////////////////////////
// packet checker top, stream in and
// table load in, one verdict per packet out
////////////////////////////////////////

`timescale 1ns/100ps

module pkt_checker_top import stream_pkg::*, check_pkg::*; (
    input  logic                  axis_in,
    input  logic                  rst,
    input  logic [DATA_W-1:0]     pkt_tdata,
    input  logic [DATA_BYTES-1:0] pkt_tkeep,
    input  logic                  pkt_tvalid,
    input  logic                  pkt_tlast,
    output logic                  pkt_tready,
    input  logic                  tbl_we,
    input  logic [SLOT_W-1:0]     tbl_slot,
    input  logic [WORD_IDX_W-1:0] tbl_word,
    input  logic [DATA_W-1:0]     tbl_wdata,
    input  logic                  len_we,
    input  logic [BLEN_W-1:0]     len_bytes,
    output logic                  verdict_valid,
    output verdict_e              verdict,
    output logic [SLOT_W-1:0]     verdict_slot,
    output logic [CNT_W-1:0]      match_count,
    output logic [CNT_W-1:0]      miss_count
);

    logic                 done;
    logic [NUM_SLOTS-1:0] cand_mask;
    logic                 bad;

    beat_if beat ();

    // stage 1, input register
    beat_decode u_decode (
        .axis_in (axis_in),
        .rst     (rst),
        .tdata   (pkt_tdata),
        .tkeep   (pkt_tkeep),
        .tvalid  (pkt_tvalid),
        .tlast   (pkt_tlast),
        .tready  (pkt_tready),
        .beat    (beat.src)
    );

    // stage 2, compare against the table
    slot_compare u_compare (
        .axis_in   (axis_in),
        .rst       (rst),
        .beat      (beat.dst),
        .tbl_we    (tbl_we),
        .tbl_slot  (tbl_slot),
        .tbl_word  (tbl_word),
        .tbl_wdata (tbl_wdata),
        .len_we    (len_we),
        .len_bytes (len_bytes),
        .done      (done),
        .cand_mask (cand_mask),
        .bad       (bad)
    );

    // stage 3, verdict and claims
    // length writes address the slot via tbl_slot
    verdict_select u_select (
        .axis_in       (axis_in),
        .rst           (rst),
        .done          (done),
        .cand_mask     (cand_mask),
        .bad           (bad),
        .len_we        (len_we),
        .len_slot      (tbl_slot),
        .verdict_valid (verdict_valid),
        .verdict       (verdict),
        .verdict_slot  (verdict_slot),
        .match_count   (match_count),
        .miss_count    (miss_count)
    );

endmodule

// File: bench/tb_clock.sv
////////////////////////////////////////
// testbench clock, 4 ns period, with reset
// held over the first 4 rising edges
////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock (
    output logic axis_in,
    output logic rst
);

    initial begin
        axis_in = 1'b0;
        forever #2 axis_in = ~axis_in;
    end

    // released on a falling edge like all stimulus
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge axis_in);
        @(negedge axis_in);
        rst = 1'b0;
    end

endmodule

// File: bench/pkt_checker_props.sv
////////////////////////////////////////
// protocol properties, bound into the
// packet checker top level
////////////////////////////////////////

`timescale 1ns/100ps

module pkt_checker_props import check_pkg::*; (
    input logic             axis_in,
    input logic             rst,
    input logic             pkt_tvalid,
    input logic             pkt_tready,
    input logic             pkt_tlast,
    input logic             verdict_valid,
    input logic [CNT_W-1:0] match_count
);

    // read by the testbench at the end
    int   fail_cnt = 0;
    logic last_acc;

    assign last_acc = pkt_tvalid && pkt_tready && pkt_tlast;

    // a second high cycle only for a tlast one edge later
    pulse_chk: assert property (@(posedge axis_in) disable iff (rst)
        verdict_valid && !$past(last_acc, 2) |=> !verdict_valid)
    else begin
        fail_cnt++;
        $error("verdict_valid high for more than one cycle per packet");
    end

    reset_chk: assert property (@(posedge axis_in) rst |=> !pkt_tready)
    else begin
        fail_cnt++;
        $error("pkt_tready high while rst is asserted");
    end

    // accept edge, beat, done, verdict
    latency_chk: assert property (@(posedge axis_in) disable iff (rst)
        last_acc |-> ##3 verdict_valid)
    else begin
        fail_cnt++;
        $error("no verdict 3 cycles after an accepted tlast");
    end

    count_chk: assert property (@(posedge axis_in) disable iff (rst)
        match_count >= $past(match_count))
    else begin
        fail_cnt++;
        $error("match_count went down");
    end

endmodule

bind pkt_checker_top pkt_checker_props u_props (.*);

// File: bench/pkt_checker_tb.sv
////////////////////////////////////////
// packet checker testbench, loads the table,
// sends packets and checks every verdict
////////////////////////////////////////

`timescale 1ns/100ps

module pkt_checker_tb import stream_pkg::*, check_pkg::*;;

    localparam int CLK_NS = 4;

    logic                  axis_in;
    logic                  rst;
    logic [DATA_W-1:0]     pkt_tdata;
    logic [DATA_BYTES-1:0] pkt_tkeep;
    logic                  pkt_tvalid;
    logic                  pkt_tlast;
    logic                  pkt_tready;
    logic                  tbl_we;
    logic [SLOT_W-1:0]     tbl_slot;
    logic [WORD_IDX_W-1:0] tbl_word;
    logic [DATA_W-1:0]     tbl_wdata;
    logic                  len_we;
    logic [BLEN_W-1:0]     len_bytes;
    logic                  verdict_valid;
    verdict_e              verdict;
    logic [SLOT_W-1:0]     verdict_slot;
    logic [CNT_W-1:0]      match_count;
    logic [CNT_W-1:0]      miss_count;

    integer seed = 32'hfc07;
    // rising edges so far
    int     cyc = 0;
    // cycles the stimulus may need so far
    int     budget = 10;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     test_err0 = 0;

    // expected packets and the model of the table
    logic [7:0] gold [NUM_SLOTS][MTU_BYTES];
    int         gold_len [NUM_SLOTS];
    logic [NUM_SLOTS-1:0][MTU_WORDS-1:0][DATA_W-1:0] m_words;
    logic [NUM_SLOTS-1:0][BLEN_W-1:0]                m_len;
    logic [NUM_SLOTS-1:0]                            m_claimed;
    int         m_match = 0;
    int         m_miss = 0;

    // packet being built
    logic [7:0]            tx_bytes [$];
    logic [DATA_W-1:0]     tx_data [$];
    logic [DATA_BYTES-1:0] tx_keep [$];

    // one entry per sent packet in send order
    verdict_e exp_vd [$];
    int       exp_slot [$];
    int       exp_match [$];
    int       exp_miss [$];
    int       exp_cyc [$];

    tb_clock u_clock (
        .axis_in (axis_in),
        .rst     (rst)
    );

    pkt_checker_top uut (.*);

    always @(posedge axis_in) begin
        cyc <= cyc + 1;
    end

    // expected verdict and slot from bytes, tkeep list, table and claims
    function automatic void ref_verdict(
        input  logic [7:0]                                  bytes [$],
        input  logic [DATA_BYTES-1:0]                       keeps [$],
        input  logic [NUM_SLOTS-1:0][MTU_WORDS-1:0][DATA_W-1:0] words,
        input  logic [NUM_SLOTS-1:0][BLEN_W-1:0]            lens,
        input  logic [NUM_SLOTS-1:0]                        claims,
        output verdict_e                                    vd,
        output int                                          slot
    );
        logic                 bad;
        logic                 gap;
        logic [NUM_SLOTS-1:0] hit;
        bad = keeps.size() > MTU_WORDS;
        for (int i = 0; i < keeps.size(); i++) begin
            // empty beat, or partial before the last
            if (keeps[i] == '0 || (i != keeps.size() - 1 && keeps[i] != '1)) begin
                bad = 1'b1;
            end
            // kept byte after a dropped one
            gap = 1'b0;
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (!keeps[i][b]) begin
                    gap = 1'b1;
                end else if (gap) begin
                    bad = 1'b1;
                end
            end
        end
        hit = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            hit[s] = lens[s] != 0 && lens[s] == bytes.size();
            for (int k = 0; k < bytes.size() && k < MTU_BYTES; k++) begin
                if (words[s][k / DATA_BYTES][8 * (k % DATA_BYTES) +: 8] != bytes[k]) begin
                    hit[s] = 1'b0;
                end
            end
        end
        vd = vd_miss;
        slot = 0;
        if (bad) begin
            vd = vd_malformed;
        end else begin
            // downward scans leave the lowest slot
            for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
                if (hit[s] && claims[s]) begin
                    vd = vd_repeat;
                    slot = s;
                end
            end
            for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
                if (hit[s] && !claims[s]) begin
                    vd = vd_match;
                    slot = s;
                end
            end
        end
    endfunction

    // first slot that can be one byte shorter and longer
    function automatic int mid_slot();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (gold_len[s] > 1 && gold_len[s] < MTU_BYTES) begin
                return s;
            end
        end
        return 0;
    endfunction

    task automatic write_word(input int s, input int w, input logic [DATA_W-1:0] d);
        tbl_we = 1'b1;
        tbl_slot = SLOT_W'(s);
        tbl_word = WORD_IDX_W'(w);
        tbl_wdata = d;
        @(negedge axis_in);
        tbl_we = 1'b0;
        m_words[s][w] = d;
        budget += 1;
    endtask

    // also frees the slot
    task automatic write_length(input int s, input int len);
        len_we = 1'b1;
        tbl_slot = SLOT_W'(s);
        len_bytes = BLEN_W'(len);
        @(negedge axis_in);
        len_we = 1'b0;
        m_len[s] = BLEN_W'(len);
        m_claimed[s] = 1'b0;
        budget += 1;
    endtask

    task automatic load_slot(input int s);
        logic [DATA_W-1:0] d;
        for (int w = 0; w < MTU_WORDS; w++) begin
            d = '0;
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (w * DATA_BYTES + b < gold_len[s]) begin
                    d[8 * b +: 8] = gold[s][w * DATA_BYTES + b];
                end
            end
            write_word(s, w, d);
        end
        write_length(s, gold_len[s]);
    endtask

    task automatic load_tx(input int s);
        tx_bytes.delete();
        for (int k = 0; k < gold_len[s]; k++) begin
            tx_bytes.push_back(gold[s][k]);
        end
    endtask

    // contiguous beats with partial keep only at the end
    task automatic make_beats();
        tx_data.delete();
        tx_keep.delete();
        for (int i = 0; i < tx_bytes.size(); i += DATA_BYTES) begin
            logic [DATA_W-1:0]     d;
            logic [DATA_BYTES-1:0] k;
            d = '0;
            k = '0;
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (i + b < tx_bytes.size()) begin
                    d[8 * b +: 8] = tx_bytes[i + b];
                    k[b] = 1'b1;
                end
            end
            tx_data.push_back(d);
            tx_keep.push_back(k);
        end
    endtask

    // drives tx beats back to back from a falling edge
    task automatic send_packet();
        logic [7:0] kept [$];
        verdict_e   vd;
        int         slot;
        for (int i = 0; i < tx_data.size(); i++) begin
            for (int b = 0; b < DATA_BYTES; b++) begin
                if (tx_keep[i][b]) begin
                    kept.push_back(tx_data[i][8 * b +: 8]);
                end
            end
        end
        ref_verdict(kept, tx_keep, m_words, m_len, m_claimed, vd, slot);
        if (vd == vd_match) begin
            m_claimed[slot] = 1'b1;
            m_match++;
        end else begin
            m_miss++;
        end
        for (int i = 0; i < tx_data.size(); i++) begin
            pkt_tvalid = 1'b1;
            pkt_tdata = tx_data[i];
            pkt_tkeep = tx_keep[i];
            pkt_tlast = (i == tx_data.size() - 1);
            if (pkt_tlast) begin
                // accepted on the next edge with the verdict two edges later
                exp_vd.push_back(vd);
                exp_slot.push_back(slot);
                exp_match.push_back(m_match);
                exp_miss.push_back(m_miss);
                exp_cyc.push_back(cyc + 3);
            end
            @(negedge axis_in);
            budget += 1;
        end
    endtask

    task automatic send_bytes();
        make_beats();
        send_packet();
    endtask

    task automatic go_idle(input int n);
        pkt_tvalid = 1'b0;
        pkt_tlast = 1'b0;
        repeat (n) @(negedge axis_in);
        budget += n;
    endtask

    task automatic drain();
        go_idle(0);
        budget += 6;
        while (exp_vd.size() != 0) begin
            @(negedge axis_in);
        end
        @(negedge axis_in);
    endtask

    task automatic end_test(input string name);
        drain();
        tests++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    // compares each verdict with the oldest expectation
    initial begin : compare
        verdict_e e_vd;
        int       e_slot;
        int       e_match;
        int       e_miss;
        int       e_cyc;
        forever begin
            @(negedge axis_in);
            if (verdict_valid === 1'b1) begin
                if (exp_vd.size() == 0) begin
                    errors++;
                    $display("verdict at %0t with no packet outstanding", $time);
                end else begin
                    e_vd = exp_vd.pop_front();
                    e_slot = exp_slot.pop_front();
                    e_match = exp_match.pop_front();
                    e_miss = exp_miss.pop_front();
                    e_cyc = exp_cyc.pop_front();
                    checks++;
                    if (verdict !== e_vd) begin
                        errors++;
                        $display("CHECK FAILED %0t: verdict %s, expected %s",
                                 $time, verdict.name(), e_vd.name());
                    end
                    if (verdict_slot !== SLOT_W'(e_slot)) begin
                        errors++;
                        $display("CHECK FAILED %0t: slot %0d, expected %0d",
                                 $time, verdict_slot, e_slot);
                    end
                    if (match_count !== CNT_W'(e_match)) begin
                        errors++;
                        $display("CHECK FAILED %0t: match_count %0d, expected %0d",
                                 $time, match_count, e_match);
                    end
                    if (miss_count !== CNT_W'(e_miss)) begin
                        errors++;
                        $display("CHECK FAILED %0t: miss_count %0d, expected %0d",
                                 $time, miss_count, e_miss);
                    end
                    if (cyc != e_cyc) begin
                        errors++;
                        $display("CHECK FAILED %0t: verdict in cycle %0d, expected %0d",
                                 $time, cyc, e_cyc);
                    end
                end
            end else if (exp_cyc.size() != 0 && cyc > exp_cyc[0]) begin
                errors++;
                $display("verdict missing at %0t, it was due in cycle %0d", $time, exp_cyc[0]);
                void'(exp_vd.pop_front());
                void'(exp_slot.pop_front());
                void'(exp_match.pop_front());
                void'(exp_miss.pop_front());
                void'(exp_cyc.pop_front());
            end
        end
    end

    initial begin : watchdog
        while ($time <= (budget + 50) * CLK_NS) begin
            @(posedge axis_in);
        end
        $display("watchdog stopped the run at %0t, the tests took too long", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int s;
        int idx;
        pkt_tvalid = 1'b0;
        pkt_tdata = '0;
        pkt_tkeep = '0;
        pkt_tlast = 1'b0;
        tbl_we = 1'b0;
        tbl_slot = '0;
        tbl_word = '0;
        tbl_wdata = '0;
        len_we = 1'b0;
        len_bytes = '0;
        m_words = '0;
        m_len = '0;
        m_claimed = '0;
        wait (rst == 1'b0);
        while (pkt_tready !== 1'b1) begin
            @(negedge axis_in);
        end

        // random packets of 1 to 64 bytes into every slot
        for (int i = 0; i < NUM_SLOTS; i++) begin
            gold_len[i] = 1 + ($unsigned($random(seed)) % MTU_BYTES);
            for (int k = 0; k < MTU_BYTES; k++) begin
                gold[i][k] = 8'($random(seed));
            end
            load_slot(i);
        end

        for (int i = 0; i < NUM_SLOTS; i++) begin
            load_tx(i);
            send_bytes();
            go_idle(2);
        end
        drain();
        if (match_count !== 4) begin
            errors++;
            $display("CHECK FAILED %0t: match_count %0d after 4 matches", $time, match_count);
        end
        end_test("match on every slot");

        load_tx(1);
        send_bytes();
        go_idle(1);
        load_tx(2);
        idx = $unsigned($random(seed)) % tx_bytes.size();
        tx_bytes[idx] = tx_bytes[idx] ^ 8'h5a;
        send_bytes();
        drain();
        if (miss_count !== 2) begin
            errors++;
            $display("CHECK FAILED %0t: miss_count %0d after repeat and miss", $time, miss_count);
        end
        end_test("repeat and altered byte");

        s = mid_slot();
        load_tx(s);
        if (tx_bytes.size() > 1) begin
            void'(tx_bytes.pop_back());
            send_bytes();
            go_idle(1);
        end
        load_tx(s);
        // zero equals the table padding so only the length differs
        tx_bytes.push_back(8'h00);
        send_bytes();
        end_test("length one byte off");

        // non-contiguous keep on the last beat
        load_tx(0);
        make_beats();
        tx_keep[tx_keep.size() - 1] = 4'b0101;
        send_packet();
        go_idle(1);
        // empty beat in the middle
        tx_bytes.delete();
        repeat (12) tx_bytes.push_back(8'($random(seed)));
        make_beats();
        tx_keep[1] = '0;
        send_packet();
        go_idle(1);
        // one beat past the MTU
        tx_bytes.delete();
        repeat (MTU_BYTES + DATA_BYTES) tx_bytes.push_back(8'($random(seed)));
        send_bytes();
        go_idle(1);
        // clean packet right after
        load_tx(3);
        send_bytes();
        end_test("malformed packets");

        write_length(2, gold_len[2]);
        load_tx(2);
        send_bytes();
        go_idle(1);
        load_tx(2);
        send_bytes();
        end_test("length write frees a slot");

        for (int i = 0; i < NUM_SLOTS; i++) begin
            write_length(i, gold_len[i]);
        end
        // no idle beats from here to the drain
        for (int i = 0; i < NUM_SLOTS; i++) begin
            load_tx(i);
            send_bytes();
        end
        repeat (3) begin
            tx_bytes.delete();
            tx_bytes.push_back(8'($random(seed)));
            send_bytes();
        end
        load_tx(0);
        send_bytes();
        tx_bytes.delete();
        tx_bytes.push_back(8'($random(seed)));
        make_beats();
        tx_keep[0] = '0;
        send_packet();
        load_tx(3);
        tx_bytes[0] = tx_bytes[0] ^ 8'h01;
        send_bytes();
        load_tx(1);
        send_bytes();
        end_test("back to back packets");

        $display("tests %0d, verdicts checked %0d, errors %0d, assertion failures %0d",
                 tests, checks, errors, uut.u_props.fail_cnt);
        if (errors == 0 && uut.u_props.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: src.f
source/stream_pkg.sv
source/check_pkg.sv
source/beat_if.sv
source/beat_decode.sv
source/expect_table.sv
source/slot_compare.sv
source/verdict_select.sv
source/pkt_checker_top.sv
bench/tb_clock.sv
bench/pkt_checker_props.sv
bench/pkt_checker_tb.sv

// File: Bender.yml
package:
  name: pkt_checker

sources:
  # packages first, then the design bottom up
  - files:
      - source/stream_pkg.sv
      - source/check_pkg.sv
      - source/beat_if.sv
      - source/beat_decode.sv
      - source/expect_table.sv
      - source/slot_compare.sv
      - source/verdict_select.sv
      - source/pkt_checker_top.sv

  # simulation only
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/pkt_checker_props.sv
      - bench/pkt_checker_tb.sv
